// ==== project.f ====
hw/rv_core_pkg.sv
hw/exec_bus_if.sv
hw/fetch.sv
hw/decode.sv
hw/regbank.sv
hw/execute.sv
hw/mem_retire.sv
hw/rv_core.sv
testbench/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_rv_core \
    && ./obj_dir/Vtb_rv_core > sim.log 2>&1 \
    || echo "Build or simulation run did not complete"
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log 2>/dev/null && exit 0 || exit 1

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps
// Testbench for rv_core: random forward-only program, one-cycle memories, ISA model, store checks
module tb_rv_core;
    import rv_core_pkg::*;

    localparam int              PROG_LEN   = 200;
    localparam int              DATA_WORDS = 64;
    localparam int              TIMEOUT    = 20000;
    localparam logic [XLEN-1:0] MARK_ADDR  = 32'd252;
    // JAL x0, 0 closes the program
    localparam logic [31:0]     HALT_INSTR = {20'h0, 5'd0, OPC_JAL};

    logic            clk;
    logic            reset_n;
    logic            stall_i;
    logic            imem_en_o;
    logic [XLEN-1:0] imem_addr_o;
    logic [XLEN-1:0] imem_data_i;
    logic            dmem_en_o;
    logic [3:0]      dmem_we_o;
    logic [XLEN-1:0] dmem_addr_o;
    logic [XLEN-1:0] dmem_wdata_o;
    logic [XLEN-1:0] dmem_rdata_i;
    logic [101:0]    core_outs;
    logic [101:0]    held_out = '0;
    logic            was_stalled = 1'b0;
    logic            first_req = 1'b0;
    logic            done = 1'b0;
    logic [31:0]     lfsr;
    logic [31:0]     imem [0:255];
    logic [31:0]     dmem [0:DATA_WORDS-1];
    logic [31:0]     exp_addr [$];
    logic [31:0]     exp_data [$];
    int              n_stores = 0;
    int              value_errs = 0;
    int              other_errs = 0;

    rv_core dut (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i),
        .imem_en_o(imem_en_o), .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .dmem_en_o(dmem_en_o), .dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o), .dmem_rdata_i(dmem_rdata_i)
    );

    assign core_outs = {imem_en_o, imem_addr_o, dmem_en_o, dmem_we_o, dmem_addr_o, dmem_wdata_o};

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Program generator
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] make_instr(input int idx);
        logic [4:0]  rd, rs1, rs2, shamt;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] ival;
        logic [11:0] woff;
        logic [12:0] boff;
        logic [20:0] joff;
        int          span;
        // Registers x0..x7 only, so hazards come often
        rd    = 5'(rand_bits(3));
        rs1   = 5'(rand_bits(3));
        rs2   = 5'(rand_bits(3));
        f3    = 3'(rand_bits(3));
        alt   = 1'b0;
        if (f3 == 3'b000 || f3 == 3'b101) alt = rand_bits(1) != 32'd0;
        shamt = 5'(rand_bits(5));
        // Word 63 is left for the marker
        woff  = {4'b0000, 6'(rand_bits(6) % 32'd63), 2'b00};
        // Forward only, never past the marker sequence
        span  = 1 + int'(rand_bits(3));
        if (idx + span > PROG_LEN) span = PROG_LEN - idx;
        boff  = 13'(span * 4);
        joff  = 21'(span * 4);
        case (3'(rand_bits(3)))
            3'd0, 3'd1: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
            3'd2: begin
                if (f3 == 3'b001) ival = {7'b0, shamt};
                else if (f3 == 3'b101) ival = {1'b0, alt, 5'b0, shamt};
                else ival = 12'(rand_bits(12));
                return {ival, rs1, f3, rd, OPC_OP_IMM};
            end
            3'd3: return {20'(rand_bits(20)), rd, OPC_LUI};
            3'd4: return {woff, 5'd0, 3'b010, rd, OPC_LOAD};
            3'd5, 3'd6: return {woff[11:5], rs2, 5'd0, 3'b010, woff[4:0], OPC_STORE};
            default: begin
                // f3 bits 2 and 0 pick BEQ, BNE, BLT or BGE
                if (rand_bits(1) != 32'd0) begin
                    return {boff[12], boff[10:5], rs2, rs1, f3[2], 1'b0, f3[0],
                            boff[4:1], boff[11], OPC_BRANCH};
                end
                return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            end
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ISA reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs the program to the halt loop, records every store in order
    task automatic run_model();
        logic [31:0] x [0:31];
        logic [31:0] mem [0:DATA_WORDS-1];
        logic [31:0] pc, npc, ins, a, b, res, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic        wr, taken;
        int          steps;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < DATA_WORDS; i++) mem[i] = dmem[i];
        pc    = START_ADDR;
        steps = 0;
        ins   = imem[pc[9:2]];
        while (ins != HALT_INSTR && steps < 4096) begin
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc   = pc + 32'd4;
            wr    = 1'b1;
            res   = '0;
            case (ins[6:0])
                OPC_OP:     res = isa_alu(ins[14:12], ins[30], a, b);
                OPC_OP_IMM: res = isa_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
                OPC_LUI:    res = {ins[31:12], 12'b0};
                OPC_LOAD: begin
                    addr = a + imm_i;
                    res  = mem[addr[7:2]];
                end
                OPC_STORE: begin
                    addr           = a + imm_s;
                    mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    wr = 1'b0;
                end
                OPC_BRANCH: begin
                    case (ins[14:12])
                        3'b000:  taken = a == b;
                        3'b001:  taken = a != b;
                        3'b100:  taken = $signed(a) < $signed(b);
                        default: taken = $signed(a) >= $signed(b);
                    endcase
                    if (taken) npc = pc + imm_b;
                    wr = 1'b0;
                end
                OPC_JAL: begin
                    res = pc + 32'd4;
                    npc = pc + imm_j;
                end
                default: wr = 1'b0;
            endcase
            // x0 stays zero
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
            pc  = npc;
            ins = imem[pc[9:2]];
            steps++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory models, stall driver and checks
    //////////////////////////////////////////////////////////////////////

    // One-cycle read latency, everything held while stalled
    always @(posedge clk) begin
        if (!stall_i && imem_en_o) imem_data_i <= imem[imem_addr_o[9:2]];
        if (!stall_i && dmem_en_o) begin
            if (dmem_we_o != 4'b0000) dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
            else dmem_rdata_i <= dmem[dmem_addr_o[7:2]];
        end
    end

    // About one stalled cycle in four
    always @(posedge clk) begin
        if (reset_n) stall_i <= (rand_bits(2) == 32'd0);
    end

    always @(posedge clk) begin
        if (reset_n && imem_en_o && !first_req) begin
            first_req <= 1'b1;
            assert (imem_addr_o == START_ADDR) else begin
                $display("FAIL imem_addr_o: expected %h got %h", START_ADDR, imem_addr_o);
                value_errs++;
            end
            assert (!dmem_en_o) else begin
                $display("Data port was active at the first instruction request");
                other_errs++;
            end
        end
        // Store accepted on this edge
        if (reset_n && !stall_i && dmem_en_o && dmem_we_o != 4'b0000) begin
            assert (n_stores < exp_addr.size()) else begin
                $display("Store %0d to %h is not in the model's store list", n_stores, dmem_addr_o);
                other_errs++;
            end
            if (n_stores < exp_addr.size()) begin
                assert (dmem_addr_o == exp_addr[n_stores]) else begin
                    $display("FAIL dmem_addr_o: expected %h got %h", exp_addr[n_stores], dmem_addr_o);
                    value_errs++;
                end
                assert (dmem_wdata_o == exp_data[n_stores]) else begin
                    $display("FAIL dmem_wdata_o: expected %h got %h", exp_data[n_stores], dmem_wdata_o);
                    value_errs++;
                end
                assert (dmem_we_o == 4'b1111) else begin
                    $display("FAIL dmem_we_o: expected %h got %h", 4'b1111, dmem_we_o);
                    value_errs++;
                end
            end
            n_stores++;
            if (dmem_addr_o == MARK_ADDR) done = 1'b1;
        end
        // Request outputs frozen across a stalled edge
        if (was_stalled) begin
            assert (core_outs == held_out) else begin
                $display("FAIL core_outs: expected %h got %h", held_out, core_outs);
                value_errs++;
            end
        end
        was_stalled <= reset_n && stall_i;
        held_out    <= core_outs;
    end

    initial begin
        int cycles;
        int end_errs;
        clk          = 1'b0;
        reset_n      = 1'b0;
        stall_i      = 1'b0;
        imem_data_i  = '0;
        dmem_rdata_i = '0;
        lfsr         = 32'h26af;
        end_errs     = 0;
        // Filler is ADDI x0 carrying its own word index
        for (int i = 0; i < 256; i++) imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
        for (int i = 0; i < PROG_LEN; i++) imem[i] = make_instr(i);
        // Marker into x1, SW x1 to word 63, then spin
        imem[PROG_LEN]     = {20'h600d5, 5'd1, OPC_LUI};
        imem[PROG_LEN + 1] = {7'd7, 5'd1, 5'd0, 3'b010, 5'd28, OPC_STORE};
        imem[PROG_LEN + 2] = HALT_INSTR;
        for (int i = 0; i < DATA_WORDS; i++) dmem[i] = 32'(i + 1) * 32'h9e37_79b9 ^ 32'h00c0_ffee;
        run_model();
        repeat (2) @(posedge clk);
        assert (!imem_en_o && !dmem_en_o && dmem_we_o == 4'b0000) else begin
            $display("Memory requests were active during reset");
            end_errs++;
        end
        reset_n <= 1'b1;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (done) else begin
            $display("Timed out after %0d cycles waiting for the marker store", cycles);
            end_errs++;
        end
        // Drain, the halt loop must not store again
        repeat (8) @(posedge clk);
        assert (n_stores == exp_addr.size()) else begin
            $display("FAIL n_stores: expected %h got %h", exp_addr.size(), n_stores);
            end_errs++;
        end
        $display("Errors: %0d value, %0d other (stores %0d of %0d)", value_errs,
                 other_errs + end_errs, n_stores, exp_addr.size());
        if (value_errs + other_errs + end_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
// RV32I core top level: connects fetch, decode, register bank, execute and retire to the memories
module rv_core (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          stall_i,
    output logic                          imem_en_o,
    output logic [rv_core_pkg::XLEN-1:0]  imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]  imem_data_i,
    output logic                          dmem_en_o,
    output logic [3:0]                    dmem_we_o,
    output logic [rv_core_pkg::XLEN-1:0]  dmem_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]  dmem_wdata_o,
    input  logic [rv_core_pkg::XLEN-1:0]  dmem_rdata_i
);
    import rv_core_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Stage to stage wiring
    //////////////////////////////////////////////////////////////////////

    // Fetch to decode
    logic                  fetch_valid;
    logic [XLEN-1:0]       fetch_pc;
    logic [XLEN-1:0]       instr;
    logic                  decode_ready;
    // Register reads
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    // Control transfer from execute
    logic                  redirect;
    logic [XLEN-1:0]       redirect_target;
    // Execute to retire
    logic                  retire_valid;
    op_e                   retire_op;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_result;
    logic                  retire_we;
    // Write-back
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    exec_bus_if exec_bus ();

    fetch u_fetch (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .decode_ready_i(decode_ready),
        .redirect_i(redirect), .redirect_target_i(redirect_target),
        .imem_data_i(imem_data_i), .imem_en_o(imem_en_o), .imem_addr_o(imem_addr_o),
        .fetch_valid_o(fetch_valid), .fetch_pc_o(fetch_pc), .instr_o(instr)
    );

    decode u_decode (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .fetch_valid_i(fetch_valid),
        .fetch_pc_i(fetch_pc), .instr_i(instr), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .redirect_i(redirect), .wb_en_i(wb_en), .wb_rd_i(wb_rd), .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr), .decode_ready_o(decode_ready), .bus(exec_bus)
    );

    regbank u_regbank (
        .clk(clk), .reset_n(reset_n), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    execute u_execute (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .bus(exec_bus),
        .redirect_o(redirect), .redirect_target_o(redirect_target),
        .dmem_en_o(dmem_en_o), .dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o), .retire_valid_o(retire_valid), .retire_op_o(retire_op),
        .retire_rd_o(retire_rd), .retire_result_o(retire_result), .retire_we_o(retire_we)
    );

    mem_retire u_mem_retire (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .retire_valid_i(retire_valid),
        .retire_op_i(retire_op), .retire_rd_i(retire_rd), .retire_result_i(retire_result),
        .retire_we_i(retire_we), .dmem_rdata_i(dmem_rdata_i),
        .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

endmodule

// ==== hw/mem_retire.sv ====
`timescale 1ns/1ps
// Retire register and write-back mux, load data taken from the data memory in this stage
module mem_retire (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                stall_i,
    input  logic                                retire_valid_i,
    input  rv_core_pkg::op_e                    retire_op_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  retire_rd_i,
    input  logic [rv_core_pkg::XLEN-1:0]        retire_result_i,
    input  logic                                retire_we_i,
    input  logic [rv_core_pkg::XLEN-1:0]        dmem_rdata_i,
    output logic                                wb_en_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]        wb_data_o
);
    import rv_core_pkg::*;

    logic                  valid_q;
    logic                  we_q;
    op_e                   op_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       result_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= retire_valid_i;
            we_q    <= retire_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            op_q     <= retire_op_i;
            rd_q     <= retire_rd_i;
            result_q <= retire_result_i;
        end
    end

    // x0 writes dropped here
    assign wb_en_o   = valid_q && we_q && (rd_q != '0);
    assign wb_rd_o   = rd_q;
    assign wb_data_o = (op_q == OP_LW) ? dmem_rdata_i : result_q;

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/1ps
// Execute stage: ALU, branch resolution, JAL link and word-aligned data memory requests
module execute (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                stall_i,
    exec_bus_if.consumer                        bus,
    output logic                                redirect_o,
    output logic [rv_core_pkg::XLEN-1:0]        redirect_target_o,
    output logic                                dmem_en_o,
    output logic [3:0]                          dmem_we_o,
    output logic [rv_core_pkg::XLEN-1:0]        dmem_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]        dmem_wdata_o,
    output logic                                retire_valid_o,
    output rv_core_pkg::op_e                    retire_op_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  retire_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]        retire_result_o,
    output logic                                retire_we_o
);
    import rv_core_pkg::*;

    logic            squash_q;
    logic            exec_valid;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sum;
    logic [4:0]      shamt;
    logic [XLEN-1:0] result;
    logic            eq;
    logic            lt;
    logic            taken;

    // Set the cycle after a redirect, covers whatever decode held then
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            squash_q <= 1'b0;
        end else if (!stall_i) begin
            squash_q <= redirect_o;
        end
    end

    assign exec_valid = bus.valid && !squash_q;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    assign op_a  = bus.rs1_data;
    assign op_b  = bus.operand_b;
    // Also the load/store address, operand_b holds the offset
    assign sum   = op_a + op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (bus.op)
            OP_ADD, OP_LW, OP_SW: result = sum;
            OP_SUB:  result = op_a - op_b;
            OP_AND:  result = op_a & op_b;
            OP_OR:   result = op_a | op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            OP_SLL:  result = op_a << shamt;
            OP_SRL:  result = op_a >> shamt;
            OP_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            OP_LUI:  result = bus.imm;
            // Link value
            OP_JAL:  result = bus.pc + INSTR_BYTES;
            default: result = '0;
        endcase
    end

    // Branch compare on the raw register values
    assign eq = bus.rs1_data == bus.rs2_data;
    assign lt = $signed(bus.rs1_data) < $signed(bus.rs2_data);

    always_comb begin
        case (bus.op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o        = exec_valid && taken;
    assign redirect_target_o = bus.pc + bus.imm;

    // Requests come straight off the execute register, read data lands in retire
    assign dmem_en_o    = exec_valid && (bus.op == OP_LW || bus.op == OP_SW);
    assign dmem_we_o    = (exec_valid && bus.op == OP_SW) ? 4'b1111 : 4'b0000;
    assign dmem_addr_o  = {sum[XLEN-1:2], 2'b00};
    assign dmem_wdata_o = bus.rs2_data;

    assign retire_valid_o  = exec_valid;
    assign retire_op_o     = bus.op;
    assign retire_rd_o     = bus.rd;
    assign retire_result_o = result;
    assign retire_we_o     = exec_valid &&
                             !(bus.op inside {OP_NOP, OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE});

endmodule

// ==== hw/regbank.sv ====
`timescale 1ns/1ps
// Integer register file with x0 tied to zero, two combinational reads and one write port
module regbank (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    input  logic                                wb_en_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd_i,
    input  logic [rv_core_pkg::XLEN-1:0]        wb_data_i,
    output logic [rv_core_pkg::XLEN-1:0]        rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]        rs2_data_o
);
    import rv_core_pkg::*;

    // x1..x31 only
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i) begin
            // wb_en never comes with rd zero
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== hw/decode.sv ====
`timescale 1ns/1ps
// Decode stage: op and immediate generation, RAW hazard bubbles and the decode/execute register
module decode (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                stall_i,
    input  logic                                fetch_valid_i,
    input  logic [rv_core_pkg::XLEN-1:0]        fetch_pc_i,
    input  logic [rv_core_pkg::XLEN-1:0]        instr_i,
    input  logic [rv_core_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]        rs2_data_i,
    input  logic                                redirect_i,
    input  logic                                wb_en_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    output logic                                decode_ready_o,
    exec_bus_if.producer                        bus
);
    import rv_core_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  writes_rd;
    logic                  hazard;
    op_e                   op;

    // Shared ALU mapping, alt is instruction bit 30
    function automatic op_e alu_op(input logic [2:0] f3, input logic alt, input logic is_reg);
        case (f3)
            3'b000:  alu_op = (alt && is_reg) ? OP_SUB : OP_ADD;
            3'b001:  alu_op = OP_SLL;
            3'b010:  alu_op = OP_SLT;
            3'b011:  alu_op = OP_SLTU;
            3'b100:  alu_op = OP_XOR;
            3'b101:  alu_op = alt ? OP_SRA : OP_SRL;
            3'b110:  alu_op = OP_OR;
            default: alu_op = OP_AND;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Fields and immediates
    //////////////////////////////////////////////////////////////////////

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign rs1        = instr_i[19:15];
    assign rs2        = instr_i[24:20];
    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        op      = OP_NOP;
        imm     = imm_i;
        use_imm = 1'b1;
        case (opcode)
            OPC_OP: begin
                use_imm = 1'b0;
                // funct7 is either all zero or the SUB/SRA form
                if (instr_i[31] == 1'b0 && instr_i[29:25] == 5'b0) begin
                    op = alu_op(funct3, instr_i[30], 1'b1);
                end
            end
            OPC_OP_IMM: op = alu_op(funct3, instr_i[30], 1'b0);
            OPC_LUI: begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_LOAD:  op = (funct3 == 3'b010) ? OP_LW : OP_NOP;
            OPC_STORE: begin
                imm = imm_s;
                op  = (funct3 == 3'b010) ? OP_SW : OP_NOP;
            end
            OPC_BRANCH: begin
                use_imm = 1'b0;
                imm     = imm_b;
                case (funct3)
                    F3_BEQ:  op = OP_BEQ;
                    F3_BNE:  op = OP_BNE;
                    F3_BLT:  op = OP_BLT;
                    F3_BGE:  op = OP_BGE;
                    default: op = OP_NOP;
                endcase
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = imm_j;
            end
            default: op = OP_NOP;
        endcase
    end

    assign writes_rd = !(op inside {OP_NOP, OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE});

    // Source matches the writer in execute or the one retiring now
    assign hazard = fetch_valid_i && (
        (rs1 != '0 && ((bus.valid && rs1 == bus.rd) || (wb_en_i && rs1 == wb_rd_i))) ||
        (rs2 != '0 && ((bus.valid && rs2 == bus.rd) || (wb_en_i && rs2 == wb_rd_i))));
    assign decode_ready_o = !stall_i && !hazard;

    //////////////////////////////////////////////////////////////////////
    // Decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus.valid <= 1'b0;
        end else if (!stall_i) begin
            // Bubble on hazard, kill on redirect
            bus.valid <= fetch_valid_i && !hazard && !redirect_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            bus.op        <= op;
            bus.pc        <= fetch_pc_i;
            bus.rs1_data  <= rs1_data_i;
            bus.rs2_data  <= rs2_data_i;
            bus.operand_b <= use_imm ? imm : rs2_data_i;
            bus.imm       <= imm;
            bus.rd        <= writes_rd ? instr_i[11:7] : '0;
        end
    end

endmodule

// ==== hw/fetch.sv ====
`timescale 1ns/1ps
// Fetch stage: program counter, instruction memory requests and pairing of returned words with pc
module fetch (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          stall_i,
    input  logic                          decode_ready_i,
    input  logic                          redirect_i,
    input  logic [rv_core_pkg::XLEN-1:0]  redirect_target_i,
    input  logic [rv_core_pkg::XLEN-1:0]  imem_data_i,
    output logic                          imem_en_o,
    output logic [rv_core_pkg::XLEN-1:0]  imem_addr_o,
    output logic                          fetch_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]  fetch_pc_o,
    output logic [rv_core_pkg::XLEN-1:0]  instr_o
);
    import rv_core_pkg::*;

    // Address being requested this cycle
    logic [XLEN-1:0] pc_q;
    logic            en_q;
    // Word on imem_data_i belongs to pend_pc_q
    logic            pend_q;
    logic [XLEN-1:0] pend_pc_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q      <= START_ADDR;
            en_q      <= 1'b0;
            pend_q    <= 1'b0;
            pend_pc_q <= '0;
        end else if (!stall_i) begin
            // Requests start one cycle out of reset
            en_q <= 1'b1;
            if (redirect_i) begin
                // Word of the current request is wrong path
                pc_q   <= redirect_target_i;
                pend_q <= 1'b0;
            end else if (!decode_ready_i) begin
                // Hazard: refetch the held word, drop the one in flight
                pc_q   <= pend_pc_q;
                pend_q <= 1'b0;
            end else if (en_q) begin
                pend_q    <= 1'b1;
                pend_pc_q <= pc_q;
                pc_q      <= pc_q + INSTR_BYTES;
            end
        end
    end

    assign imem_en_o     = en_q;
    assign imem_addr_o   = pc_q;
    assign fetch_valid_o = pend_q;
    assign fetch_pc_o    = pend_pc_q;
    assign instr_o       = imem_data_i;

endmodule

// ==== hw/exec_bus_if.sv ====
`timescale 1ns/1ps
// Decoded instruction bundle from the decode register into execute, one instruction per cycle
interface exec_bus_if;
    import rv_core_pkg::*;

    // Qualifies the whole bundle
    logic                   valid;
    op_e                    op;
    // Address of the instruction, base for branch and JAL targets
    logic [XLEN-1:0]        pc;
    logic [XLEN-1:0]        rs1_data;
    // Store data and branch compare operand
    logic [XLEN-1:0]        rs2_data;
    // Second ALU operand, rs2 or the immediate
    logic [XLEN-1:0]        operand_b;
    logic [XLEN-1:0]        imm;
    // Zero for ops without a destination
    logic [REG_ADDR_W-1:0]  rd;

    // Decode side
    modport producer (
        output valid, op, pc, rs1_data, rs2_data, operand_b, imm, rd
    );

    // Execute side
    modport consumer (
        input  valid, op, pc, rs1_data, rs2_data, operand_b, imm, rd
    );

endinterface

// ==== hw/rv_core_pkg.sv ====
// Shared widths, RV32I opcode constants and decoded operation codes, imported by every core block
package rv_core_pkg;

    // Datapath and register file sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Reset vector and sequential fetch step
    localparam logic [XLEN-1:0] START_ADDR  = '0;
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes, instruction bits 6:0
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Branch compare kinds in funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    //////////////////////////////////////////////////////////////////////
    // Operation chosen by decode
    //////////////////////////////////////////////////////////////////////

    // Unsupported encodings fall back to OP_NOP
    typedef enum logic [4:0] {
        OP_NOP,
        // Register and immediate ALU ops
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        // Upper immediate and word memory access
        OP_LUI,
        OP_LW,
        OP_SW,
        // Control transfer
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL
    } op_e;

endpackage
